// File: uart_hex_pkg.sv
// Shared widths, ASCII codes, default periods and digit encoder used by every hex printer block
`default_nettype none

package uart_hex_pkg;

   ////////////////////////////////////////
   // Data widths
   ////////////////////////////////////////
   typedef logic [15:0] sample_t;   // Counted value, printed as hex
   typedef logic [3:0]  nibble_t;   // One hex digit
   typedef logic [7:0]  char_t;     // One ASCII character on the wire

   ////////////////////////////////////////
   // Clock and rates
   ////////////////////////////////////////
   localparam int CLOCK_HZ       = 50_000_000;   // Board oscillator
   localparam int SAMPLE_RATE_HZ = 10;           // Values per second
   localparam int BAUD_RATE      = 115_200;

   // Clock cycles per new value and per serial bit
   localparam int DEFAULT_SAMPLE_CYCLES = CLOCK_HZ / SAMPLE_RATE_HZ;   // 5 million
   localparam int DEFAULT_BIT_CYCLES    = CLOCK_HZ / BAUD_RATE;        // 434

   localparam int DIGITS_PER_LINE = 4;   // Hex digits in a 16-bit value

   // ASCII codes
   localparam char_t CHAR_LF      = 8'h0A;   // Line feed
   localparam char_t CHAR_CR      = 8'h0D;   // Carriage return
   localparam char_t CHAR_ZERO    = 8'h30;   // Base for 0..9
   localparam char_t CHAR_UPPER_A = 8'h41;   // Base for A..F

   ////////////////////////////////////////
   // State encodings
   ////////////////////////////////////////
   // Line formatter
   typedef enum logic [1:0] {
      line_idle,   // Waiting for a new value
      line_send,   // Offering one character
      line_wait    // Character in flight
   } line_state_t;

   // Serial transmitter
   typedef enum logic [1:0] {
      tx_idle,
      tx_start,
      tx_data,
      tx_stop
   } tx_state_t;

   // Nibble to upper-case hex digit
   function automatic char_t hex_to_ascii(input nibble_t digit);
      if (digit < 4'd10)
         return CHAR_ZERO + char_t'(digit);
      else
         return CHAR_UPPER_A + char_t'(digit - 4'd10);   // A..F
   endfunction

endpackage

`default_nettype wire

// File: sample_source.sv
// Free-running sample generator; steps a 16-bit count once per sample period with a strobe
`default_nettype none
`timescale 1ns/100ps

module sample_source #(
   parameter int SAMPLE_CYCLES = uart_hex_pkg::DEFAULT_SAMPLE_CYCLES
) (
   input  logic                  CLOCK_50,
   input  logic                  reset,
   output uart_hex_pkg::sample_t sample_value,    // Current count, also shown at top
   output logic                  sample_strobe    // High in the cycle a new count appears
);

   // Period counter width, at least one bit
   localparam int CNT_W = (SAMPLE_CYCLES > 1) ? $clog2(SAMPLE_CYCLES) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SAMPLE_CYCLES - 1);

   logic [CNT_W-1:0] period_cnt;   // Cycles into the current period

   ////////////////////////////////////////
   // Period timer and value
   ////////////////////////////////////////
   always_ff @(posedge CLOCK_50)
   begin
      if (reset)
      begin
         period_cnt    <= '0;
         sample_value  <= '0;   // Count restarts at zero
         sample_strobe <= 1'b0;
      end
      else if (period_cnt == CNT_LAST)
      begin
         period_cnt    <= '0;   // Wrap
         sample_value  <= sample_value + uart_hex_pkg::sample_t'(1);
         sample_strobe <= 1'b1;   // One-cycle pulse with the new value
      end
      else
      begin
         period_cnt    <= period_cnt + CNT_W'(1);
         sample_strobe <= 1'b0;
      end
   end

   // Strobe is a single-cycle pulse per period
   a_strobe_single: assert property (@(posedge CLOCK_50) disable iff (reset)
      sample_strobe |=> !sample_strobe);

endmodule

`default_nettype wire

// File: hex_line_formatter.sv
// Line formatter; turns each strobed value into four hex digits, LF and CR for the transmitter
`default_nettype none
`timescale 1ns/100ps

module hex_line_formatter (
   input  logic                  CLOCK_50,
   input  logic                  reset,
   input  uart_hex_pkg::sample_t sample_value,
   input  logic                  sample_strobe,
   output uart_hex_pkg::char_t   tx_char,     // Character offered to the UART
   output logic                  tx_send,     // One-cycle send request
   input  logic                  tx_busy      // UART frame in progress
);

   // Character positions after the digits
   localparam logic [2:0] IDX_LF = 3'(uart_hex_pkg::DIGITS_PER_LINE);
   localparam logic [2:0] IDX_CR = 3'(uart_hex_pkg::DIGITS_PER_LINE + 1);

   uart_hex_pkg::line_state_t state;
   uart_hex_pkg::sample_t     sample_hold;   // Latched value, digits leave from the top
   logic [2:0]                char_idx;      // 0..3 digits, then LF, CR
   uart_hex_pkg::nibble_t     digit;

   ////////////////////////////////////////
   // Character select and send request
   ////////////////////////////////////////
   assign digit   = sample_hold[$bits(uart_hex_pkg::sample_t)-1 -: 4];   // Highest remaining
   assign tx_send = (state == uart_hex_pkg::line_send) && !tx_busy;

   always_comb
   begin
      if (char_idx == IDX_LF)
         tx_char = uart_hex_pkg::CHAR_LF;
      else if (char_idx == IDX_CR)
         tx_char = uart_hex_pkg::CHAR_CR;
      else
         tx_char = uart_hex_pkg::hex_to_ascii(digit);
   end

   ////////////////////////////////////////
   // Line state machine
   ////////////////////////////////////////
   always_ff @(posedge CLOCK_50)
   begin
      if (reset)
      begin
         state    <= uart_hex_pkg::line_idle;
         char_idx <= '0;
      end
      else
      begin
         case (state)
            uart_hex_pkg::line_idle:
            begin
               char_idx <= '0;
               if (sample_strobe)
                  state <= uart_hex_pkg::line_send;   // Value latched below
            end
            uart_hex_pkg::line_send:
            begin
               if (tx_send && char_idx == IDX_CR)
                  state <= uart_hex_pkg::line_idle;   // Line done
               else if (tx_send)
               begin
                  state    <= uart_hex_pkg::line_wait;
                  char_idx <= char_idx + 3'd1;
               end
            end
            uart_hex_pkg::line_wait:
            begin
               if (!tx_busy)
                  state <= uart_hex_pkg::line_send;   // Frame finished, offer next
            end
            default: state <= uart_hex_pkg::line_idle;
         endcase
      end
   end

   // Value holding register, shifted one digit per send
   always_ff @(posedge CLOCK_50)
   begin
      if (state == uart_hex_pkg::line_idle && sample_strobe)
         sample_hold <= sample_value;
      else if (tx_send)
         sample_hold <= sample_hold << 4;
   end

   // UART takes every send and reports busy in the next cycle
   a_send_idle: assert property (@(posedge CLOCK_50) disable iff (reset)
      tx_send |=> tx_busy);

endmodule

`default_nettype wire

// File: uart_tx.sv
// 8N1 serial transmitter; sends one character per tx_send pulse and reports busy for the frame
`default_nettype none
`timescale 1ns/100ps

module uart_tx #(
   parameter int BIT_CYCLES = uart_hex_pkg::DEFAULT_BIT_CYCLES
) (
   input  logic                CLOCK_50,
   input  logic                reset,
   input  uart_hex_pkg::char_t tx_char,   // Sampled with tx_send
   input  logic                tx_send,
   output logic                tx_busy,   // High from start bit to end of stop bit
   output logic                txd        // Serial line, idles high
);

   // Bit period counter width, at least one bit
   localparam int CNT_W = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BIT_CYCLES - 1);

   uart_hex_pkg::tx_state_t state;
   logic [CNT_W-1:0]        bit_cnt;     // Cycles into the current bit
   logic [2:0]              bit_idx;     // Data bit being sent
   uart_hex_pkg::char_t     shift_reg;   // Remaining data bits, LSB next
   logic                    bit_tick;    // Last cycle of a bit
   logic                    next_data;   // Move the next data bit onto the line

   assign bit_tick  = (bit_cnt == CNT_LAST);
   assign tx_busy   = (state != uart_hex_pkg::tx_idle);
   assign next_data = bit_tick && ((state == uart_hex_pkg::tx_start) ||
                      (state == uart_hex_pkg::tx_data && bit_idx != 3'd7));

   ////////////////////////////////////////
   // Bit timing
   ////////////////////////////////////////
   // Restarts with every frame so all bits are equal length
   always_ff @(posedge CLOCK_50)
   begin
      if (reset || state == uart_hex_pkg::tx_idle)
         bit_cnt <= '0;
      else if (bit_tick)
         bit_cnt <= '0;
      else
         bit_cnt <= bit_cnt + CNT_W'(1);
   end

   ////////////////////////////////////////
   // Frame state machine
   ////////////////////////////////////////
   always_ff @(posedge CLOCK_50)
   begin
      if (reset)
      begin
         state   <= uart_hex_pkg::tx_idle;
         bit_idx <= '0;
         txd     <= 1'b1;   // Line idle
      end
      else
      begin
         case (state)
            uart_hex_pkg::tx_idle:
            begin
               bit_idx <= '0;
               if (tx_send)
               begin
                  state <= uart_hex_pkg::tx_start;
                  txd   <= 1'b0;   // Start bit
               end
               else
                  txd <= 1'b1;
            end
            uart_hex_pkg::tx_start:
            begin
               if (bit_tick)
               begin
                  state <= uart_hex_pkg::tx_data;
                  txd   <= shift_reg[0];   // Bit 0 first
               end
            end
            uart_hex_pkg::tx_data:
            begin
               if (bit_tick && bit_idx == 3'd7)
               begin
                  state <= uart_hex_pkg::tx_stop;
                  txd   <= 1'b1;   // Stop bit
               end
               else if (bit_tick)
               begin
                  bit_idx <= bit_idx + 3'd1;
                  txd     <= shift_reg[0];
               end
            end
            uart_hex_pkg::tx_stop:
            begin
               if (bit_tick)
                  state <= uart_hex_pkg::tx_idle;   // Busy drops next cycle
            end
            default: state <= uart_hex_pkg::tx_idle;
         endcase
      end
   end

   // Data shifter
   always_ff @(posedge CLOCK_50)
   begin
      if (state == uart_hex_pkg::tx_idle && tx_send)
         shift_reg <= tx_char;
      else if (next_data)
         shift_reg <= shift_reg >> 1;
   end

   // Line stays at mark level between frames
   a_idle_high: assert property (@(posedge CLOCK_50) disable iff (reset)
      (state == uart_hex_pkg::tx_idle) |-> txd);

endmodule

`default_nettype wire

// File: uart_hex_top.sv
// Top level of the hex printer; counts values and prints each as a hex line on the serial pin
`default_nettype none
`timescale 1ns/100ps

module uart_hex_top #(
   parameter int SAMPLE_CYCLES = uart_hex_pkg::DEFAULT_SAMPLE_CYCLES,   // Clocks per value
   parameter int BIT_CYCLES    = uart_hex_pkg::DEFAULT_BIT_CYCLES       // Clocks per bit
) (
   input  logic                  CLOCK_50,
   input  logic                  reset,
   output logic                  txd,          // Serial out
   output uart_hex_pkg::sample_t count_value   // Current value, for LEDs
);

   uart_hex_pkg::sample_t sample_value;
   logic                  sample_strobe;
   uart_hex_pkg::char_t   tx_char;
   logic                  tx_send;
   logic                  tx_busy;

   assign count_value = sample_value;

   ////////////////////////////////////////
   // Value source
   ////////////////////////////////////////
   sample_source #(
      .SAMPLE_CYCLES (SAMPLE_CYCLES)
   ) sample_source_inst (
      .CLOCK_50      (CLOCK_50),
      .reset         (reset),
      .sample_value  (sample_value),
      .sample_strobe (sample_strobe)
   );

   // Four digits, LF, CR per value
   hex_line_formatter hex_line_formatter_inst (
      .CLOCK_50      (CLOCK_50),
      .reset         (reset),
      .sample_value  (sample_value),
      .sample_strobe (sample_strobe),
      .tx_char       (tx_char),
      .tx_send       (tx_send),
      .tx_busy       (tx_busy)
   );

   // Serial line driver
   uart_tx #(
      .BIT_CYCLES (BIT_CYCLES)
   ) uart_tx_inst (
      .CLOCK_50 (CLOCK_50),
      .reset    (reset),
      .tx_char  (tx_char),
      .tx_send  (tx_send),
      .tx_busy  (tx_busy),
      .txd      (txd)
   );

endmodule

`default_nettype wire

// File: tb_uart_hex.sv
// Directed testbench for the hex printer; decodes the serial line and checks each printed line
`default_nettype none
`timescale 1ns/100ps

module tb_uart_hex;

   localparam int BIT_CYCLES     = 8;                   // Short serial bit
   localparam int SAMPLE_CYCLES  = 600;                 // One line of 480 cycles plus gaps
   localparam int RESET_CYCLES   = 10;
   localparam int DRIVE_DELAY    = 5;                   // ns after the rising edge
   localparam int START_TIMEOUT  = 2 * SAMPLE_CYCLES;   // Cycles allowed before a start bit
   localparam int CHARS_PER_LINE = 6;                   // Four digits, LF, CR
   localparam int SEED           = 32'hd62;

   logic        CLOCK_50;
   logic        reset;
   logic        txd;
   logic [15:0] count_value;

   int          error_count;
   int          check_count;
   bit          timed_out;                           // Stops the remaining tests
   logic [7:0]  line_chars [CHARS_PER_LINE];         // Last received line
   logic [15:0] line_count;                          // count_value at its first start bit

   uart_hex_top #(
      .SAMPLE_CYCLES (SAMPLE_CYCLES),
      .BIT_CYCLES    (BIT_CYCLES)
   ) uart_hex_top_inst (
      .CLOCK_50    (CLOCK_50),
      .reset       (reset),
      .txd         (txd),
      .count_value (count_value)
   );

   // 40 ns clock
   initial
   begin
      CLOCK_50 = 1'b0;
      forever #20 CLOCK_50 = ~CLOCK_50;
   end

   ////////////////////////////////////////
   // Checks and reference model
   ////////////////////////////////////////
   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      check_count++;
      assert (actual === expected)
      else
      begin
         error_count++;
         $display("CHECK FAILED at %0t: %s expected 0x%0h got 0x%0h",
                  $time, name, expected, actual);
      end
   endtask

   // Character idx of the line printed for value
   function automatic logic [7:0] expected_char(input logic [15:0] value, input int idx);
      string      hex_digits = "0123456789ABCDEF";
      logic [3:0] nibble;
      nibble = 4'(value >> (12 - 4 * idx));   // Highest digit first
      if (idx < 4)
         return hex_digits[nibble];
      else if (idx == 4)
         return 8'h0A;   // LF
      else
         return 8'h0D;   // CR
   endfunction

   task automatic check_line(input logic [15:0] value);
      for (int i = 0; i < CHARS_PER_LINE; i++)
         check_value($sformatf("line char %0d", i), 32'(line_chars[i]),
                     32'(expected_char(value, i)));
   endtask

   ////////////////////////////////////////
   // Reset and serial receiver
   ////////////////////////////////////////
   task automatic apply_reset();
      @(posedge CLOCK_50);
      #DRIVE_DELAY reset = 1'b1;
      for (int i = 0; i < RESET_CYCLES; i++)
      begin
         @(negedge CLOCK_50);
         if (i > 0)   // First negedge comes before the first reset edge
         begin
            check_value("txd", 32'(txd), 32'd1);
            check_value("count_value", 32'(count_value), 32'd0);
         end
         @(posedge CLOCK_50);
      end
      #DRIVE_DELAY reset = 1'b0;
   endtask

   // Polls txd at falling clock edges until the line goes low
   task automatic wait_start_bit(output bit found);
      found = 1'b0;
      for (int i = 0; i < START_TIMEOUT; i++)
      begin
         @(negedge CLOCK_50);
         if (txd == 1'b0)
         begin
            found = 1'b1;
            return;
         end
      end
      timed_out = 1'b1;
      error_count++;
      $display("Timeout at %0t: no start bit on txd within %0d cycles",
               $time, START_TIMEOUT);
   endtask

   task automatic receive_char(output logic [7:0] rx, output logic [15:0] start_count,
                               output bit ok);
      bit found;
      rx = '0;
      wait_start_bit(found);
      ok = found;
      start_count = count_value;
      if (!found)
         return;
      repeat (BIT_CYCLES / 2) @(negedge CLOCK_50);   // Middle of start bit
      assert (txd == 1'b0)
      else
      begin
         error_count++;
         $display("Start bit at %0t went high before its middle", $time);
      end
      for (int b = 0; b < 8; b++)
      begin
         repeat (BIT_CYCLES) @(negedge CLOCK_50);
         rx[b] = txd;   // LSB first
      end
      repeat (BIT_CYCLES) @(negedge CLOCK_50);
      assert (txd == 1'b1)
      else
      begin
         error_count++;
         $display("Bad stop bit at %0t: txd is low in the middle of the stop bit", $time);
      end
   endtask

   task automatic receive_line(output bit ok);
      logic [7:0]  rx;
      logic [15:0] start_count;
      ok = 1'b0;
      for (int i = 0; i < CHARS_PER_LINE; i++)
      begin
         receive_char(rx, start_count, ok);
         if (!ok)
            return;
         line_chars[i] = rx;
         if (i == 0)
            line_count = start_count;   // Value shown when the line starts
      end
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////
   task automatic test_reset_idle();
      apply_reset();
      for (int i = 0; i < SAMPLE_CYCLES - RESET_CYCLES; i++)
      begin
         @(negedge CLOCK_50);
         check_value("txd", 32'(txd), 32'd1);   // Quiet until the first value
         check_value("count_value", 32'(count_value), 32'd0);
      end
   endtask

   task automatic test_first_line();
      bit ok;
      receive_line(ok);
      if (!ok)
         return;
      check_value("count_value", 32'(line_count), 32'd1);
      check_line(16'h0001);
   endtask

   // Three more lines, one value apart
   task automatic test_value_tracking();
      bit          ok;
      logic [15:0] prev_count;
      prev_count = line_count;
      for (int n = 0; n < 3; n++)
      begin
         receive_line(ok);
         if (!ok)
            return;
         check_value("count_value", 32'(line_count), 32'(prev_count + 16'd1));
         check_line(line_count);
         prev_count = line_count;
      end
   endtask

   task automatic test_mid_line_reset();
      bit ok;
      wait_start_bit(ok);
      if (!ok)
         return;
      repeat (3 * BIT_CYCLES) @(negedge CLOCK_50);   // Inside the data bits
      apply_reset();
      receive_line(ok);
      if (!ok)
         return;
      check_value("count_value", 32'(line_count), 32'd1);
      check_line(16'h0001);   // Count restarted
   endtask

   // Start bit of "1" (0x31), followed by a high bit 0
   task automatic test_bit_timing();
      bit          ok;
      logic [7:0]  rx;
      logic [15:0] start_count;
      int          low_cycles;
      apply_reset();
      for (int i = 0; i < 3; i++)
      begin
         receive_char(rx, start_count, ok);
         if (!ok)
            return;
         check_value("leading digit", 32'(rx), 32'h30);
      end
      wait_start_bit(ok);
      if (!ok)
         return;
      low_cycles = 0;
      while (txd == 1'b0 && low_cycles < 4 * BIT_CYCLES)
      begin
         low_cycles++;
         @(negedge CLOCK_50);
      end
      if (txd == 1'b0)
      begin
         error_count++;
         $display("Timeout at %0t: start bit did not end", $time);
      end
      check_value("start bit cycles", 32'(low_cycles), 32'(BIT_CYCLES));
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////
   initial
   begin
      reset       = 1'b1;
      error_count = 0;
      check_count = 0;
      timed_out   = 1'b0;
      void'($urandom(SEED));
      test_reset_idle();
      if (!timed_out)
         test_first_line();
      if (!timed_out)
         test_value_tracking();
      if (!timed_out)
         test_mid_line_reset();
      if (!timed_out)
         test_bit_timing();
      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
uart_hex_pkg.sv
sample_source.sv
hex_line_formatter.sv
uart_tx.sv
uart_hex_top.sv
tb_uart_hex.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the hex printer testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f tb.f --top-module tb_uart_hex -Mdir "$OBJ_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/Vtb_uart_hex" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi
